// File: flist.f
+incdir+test
src/gf_pkg.sv
src/bch_pkg.sv
src/bch_bit_if.sv
src/lfsr_counter.sv
src/bch_syndrome_unit.sv
src/bch_syndrome.sv
src/bch_syndrome_shuffle.sv
src/bch_syndrome_top.sv
test/tb_bch_syndrome.sv

// File: src/bch_bit_if.sv
`timescale 1ns/100ps

// serial received-bit stream, one bit per valid/ready handshake.
interface bch_bit_if;

	logic valid;
	logic ready;
	logic data;	// highest coefficient first.
	logic first;	// marks bit 0 of a codeword.

	modport source (
		output valid,
		output data,
		output first,
		input  ready
	);

	modport sink (
		input  valid,
		input  data,
		input  first,
		output ready
	);

endinterface

// File: src/bch_pkg.sv
package bch_pkg;

	import gf_pkg::*;

	function automatic int syn_count(input int t);
		return t;	// one unit per odd syndrome.
	endfunction

	// maps unit index 0 to S_1, 1 to S_3 and so on.
	function automatic int idx2syn(input int idx);
		return 2 * idx + 1;
	endfunction

	// size of the cyclotomic coset of j.
	function automatic int min_poly_degree(input int m, input int j);
		int n;
		int c;
		int deg;
		n = (1 << m) - 1;
		c = j % n;
		deg = m;
		for (int i = 1; i <= MAX_M; i++) begin
			c = (2 * c) % n;
			if (deg == m && i < m && c == j % n)
				deg = i;
		end
		return deg;
	endfunction

	// product of (x + beta) over the conjugates beta of alpha^j.
	function automatic logic [MAX_M:0] min_poly(input int m, input int j);
		logic [MAX_M-1:0] c [0:MAX_M];
		logic [MAX_M-1:0] beta;
		logic [MAX_M:0] p;
		int n;
		int e;
		int deg;
		n = (1 << m) - 1;
		e = j % n;
		deg = min_poly_degree(m, j);
		for (int k = 0; k <= MAX_M; k++)
			c[k] = '0;
		c[0] = 1;
		for (int i = 0; i < MAX_M; i++) begin
			if (i < deg) begin
				beta = alpha_pow(m, e);
				for (int k = MAX_M; k >= 1; k--)
					c[k] = c[k-1] ^ gf_mul(m, c[k], beta);
				c[0] = gf_mul(m, c[0], beta);
				e = (2 * e) % n;
			end
		end
		for (int k = 0; k <= MAX_M; k++)
			p[k] = c[k][0];	// coefficients end up in GF(2).
		return p;
	endfunction

	// 0 is the remainder method, 1 the Horner accumulator.
	function automatic int syndrome_method(input int m, input int j);
		return (min_poly_degree(m, j) == m) ? 0 : 1;
	endfunction

	// fibonacci step with the newest bit entering at the top.
	function automatic logic [MAX_M-1:0] lfsr_next(input int m, input logic [MAX_M-1:0] s);
		logic [MAX_M-1:0] poly;
		logic [MAX_M-1:0] nxt;
		poly = MAX_M'(prim_poly(m));
		nxt = s >> 1;
		nxt[m-1] = ^(s & poly);
		return nxt;
	endfunction

	function automatic int lfsr_final(input int m);
		logic [MAX_M-1:0] s;
		s = 1;
		for (int i = 0; i < (1 << m) - 2; i++)
			s = lfsr_next(m, s);
		return int'(s);
	endfunction

endpackage

// File: src/bch_syndrome.sv
`timescale 1ns/100ps

// syndromes S_1 .. S_(2T-1) of one serial codeword.
module bch_syndrome #(
	parameter int M = 4,
	parameter int T = 3
) (
	input  logic                     clk,
	input  logic                     rst_n,
	bch_bit_if.sink                  bits,
	output logic                     syn_valid,
	input  logic                     syn_ready,
	output logic [(2*T-1)*M-1:0]     syn_data
);
	import gf_pkg::*;
	import bch_pkg::*;

	localparam int ODD = syn_count(T);
	localparam logic [M-1:0] LAST = M'(lfsr_final(M));	// count seen with bit n.

	logic live;	// low until the first cycle after reset.
	logic busy;	// inside a codeword.
	logic accept;
	logic restart;
	logic last;
	logic [M-1:0] count;
	wire [M-1:0] syn [1:2*T-1];

	// a held block stops the stream until the shuffle takes it.
	assign bits.ready = live && (!syn_valid || syn_ready);
	assign accept = bits.valid && bits.ready;
	assign restart = accept && bits.first;
	assign last = accept && busy && !bits.first && count == LAST;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			live <= 1'b0;
			busy <= 1'b0;
			syn_valid <= 1'b0;
		end else begin
			live <= 1'b1;
			if (restart)
				busy <= 1'b1;	// also restarts a word cut short.
			else if (last)
				busy <= 1'b0;
			if (last)
				syn_valid <= 1'b1;
			else if (syn_ready)
				syn_valid <= 1'b0;
		end
	end

	lfsr_counter #(
		.M(M)
	) u_counter (
		.clk(clk),
		.rst_n(rst_n),
		.restart(restart),
		.advance(accept),
		.count(count)
	);

	// one accumulator per odd syndrome.
	for (genvar i = 0; i < ODD; i++) begin : g_unit
		bch_syndrome_unit #(
			.M(M),
			.T(T),
			.J(idx2syn(i))
		) u_unit (
			.clk(clk),
			.clear(restart),
			.shift(accept),
			.data(bits.data),
			.syn(syn[idx2syn(i)])
		);
	end

	// expand logic squares S_k into S_2k.
	for (genvar j = 2; j < 2 * T; j += 2) begin : g_even
		assign syn[j] = M'(gf_sq(M, syn[j/2]));
	end

	for (genvar j = 1; j < 2 * T; j++) begin : g_pack
		assign syn_data[(j-1)*M +: M] = syn[j];	// S_1 in the lowest slot.
	end

	assert property (@(posedge clk) disable iff (!rst_n)
			syn_valid && !syn_ready |=> syn_valid)
		else $error("syndrome block withdrawn before the shuffle took it.");

	assert property (@(posedge clk) disable iff (!rst_n)
			accept && !busy |-> bits.first)
		else $error("bit accepted outside a codeword without the first flag.");

endmodule

// File: src/bch_syndrome_shuffle.sv
`timescale 1ns/100ps

// rotating syndrome window in the order the solver reads it.
module bch_syndrome_shuffle #(
	parameter int M = 4,
	parameter int T = 3
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     syn_valid,
	output logic                     syn_ready,
	input  logic [(2*T-1)*M-1:0]     syn_data,
	input  logic                     step,
	input  logic                     win_release,
	output logic                     win_valid,
	output logic [(2*T-1)*M-1:0]     win_data
);

	localparam int SLOTS = 2 * T - 1;

	logic [M-1:0] slot [SLOTS];
	logic load;

	assign syn_ready = !win_valid || win_release;
	assign load = syn_valid && syn_ready;

	always_ff @(posedge clk) begin
		if (!rst_n)
			win_valid <= 1'b0;
		else if (load)
			win_valid <= 1'b1;	// load wins over release.
		else if (win_release)
			win_valid <= 1'b0;
	end

	// slot i loads S_k with k = ((2T+1-i) mod (2T-1)) + 1.
	always_ff @(posedge clk) begin
		for (int i = 0; i < SLOTS; i++) begin
			if (load)
				slot[i] <= syn_data[((2 * T + 1 - i) % SLOTS) * M +: M];
			else if (step && win_valid)
				slot[i] <= slot[(i + 2 * T - 3) % SLOTS];	// rotate.
		end
	end

	for (genvar i = 0; i < SLOTS; i++) begin : g_out
		assign win_data[i*M +: M] = slot[i];
	end

	assert property (@(posedge clk) disable iff (!rst_n) step |-> win_valid)
		else $error("solver stepped an empty syndrome window.");

endmodule

// File: src/bch_syndrome_top.sv
`timescale 1ns/100ps

module bch_syndrome_top #(
	parameter int M = 4,
	parameter int T = 3
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     bit_valid,
	output logic                     bit_ready,
	input  logic                     bit_data,
	input  logic                     bit_first,
	input  logic                     step,
	input  logic                     win_release,
	output logic                     win_valid,
	output logic [(2*T-1)*M-1:0]     win_data
);

	logic syn_valid;
	logic syn_ready;
	logic [(2*T-1)*M-1:0] syn_data;

	bch_bit_if bits ();

	// the top is the source side of the stream.
	assign bits.valid = bit_valid;
	assign bits.data = bit_data;
	assign bits.first = bit_first;
	assign bit_ready = bits.ready;

	bch_syndrome #(
		.M(M),
		.T(T)
	) u_syndrome (
		.clk(clk),
		.rst_n(rst_n),
		.bits(bits.sink),
		.syn_valid(syn_valid),
		.syn_ready(syn_ready),
		.syn_data(syn_data)
	);

	bch_syndrome_shuffle #(
		.M(M),
		.T(T)
	) u_shuffle (
		.clk(clk),
		.rst_n(rst_n),
		.syn_valid(syn_valid),
		.syn_ready(syn_ready),
		.syn_data(syn_data),
		.step(step),
		.win_release(win_release),
		.win_valid(win_valid),
		.win_data(win_data)
	);

endmodule

// File: src/bch_syndrome_unit.sv
`timescale 1ns/100ps

module bch_syndrome_unit #(
	parameter int M = 4,
	parameter int T = 3,
	parameter int J = 1
) (
	input  logic         clk,
	input  logic         clear,
	input  logic         shift,
	input  logic         data,
	output logic [M-1:0] syn
);
	import gf_pkg::*;
	import bch_pkg::*;

	localparam int DEG = min_poly_degree(M, J);
	localparam logic [DEG:0] POLY = (DEG + 1)'(min_poly(M, J));

	if (J >= 2 * T || J % 2 == 0) begin : g_chk
		$error("syndrome index %0d is not an odd index below 2T.", J);
	end

	if (syndrome_method(M, J) == 0) begin : g_rem
		logic [DEG-1:0] rem;	// r(x) mod m_J(x).
		logic [DEG:0] nxt;

		always_comb begin
			nxt = {(clear ? {DEG{1'b0}} : rem), data};	// times x, plus the new bit.
			if (nxt[DEG])
				nxt = nxt ^ POLY;
		end

		always_ff @(posedge clk) begin
			if (shift)
				rem <= nxt[DEG-1:0];
			else if (clear)
				rem <= '0;
		end

		// evaluate the remainder at alpha^J.
		always_comb begin
			syn = '0;
			for (int k = 0; k < DEG; k++)
				if (rem[k])
					syn = syn ^ M'(alpha_pow(M, J * k));
		end
	end else begin : g_horner
		localparam logic [M-1:0] ALPHA_J = M'(alpha_pow(M, J));
		logic [M-1:0] acc;
		logic [M-1:0] base;

		assign base = clear ? '0 : acc;

		always_ff @(posedge clk) begin
			if (shift)
				acc <= M'(gf_mul(M, base, ALPHA_J)) ^ {{(M - 1){1'b0}}, data};
			else if (clear)
				acc <= '0;
		end

		assign syn = acc;	// already S_J.
	end

endmodule

// File: src/gf_pkg.sv
package gf_pkg;

	localparam int MAX_M = 16;	// largest supported field degree.

	// primitive polynomial for GF(2^m) including bit m.
	function automatic int prim_poly(input int m);
		case (m)
			2: return 'h7;
			3: return 'hb;
			4: return 'h13;	// x^4 + x + 1.
			5: return 'h25;
			6: return 'h43;
			7: return 'h89;
			8: return 'h11d;
			9: return 'h211;
			10: return 'h409;
			11: return 'h805;
			12: return 'h1053;
			13: return 'h201b;
			14: return 'h4443;
			15: return 'h8003;
			16: return 'h1002d;
			default: return 0;
		endcase
	endfunction

	// shift and add multiply that reduces after every shift.
	function automatic logic [MAX_M-1:0] gf_mul(input int m, input logic [MAX_M-1:0] a,
			input logic [MAX_M-1:0] b);
		logic [MAX_M:0] p;
		logic [MAX_M:0] poly;
		p = '0;
		poly = (MAX_M+1)'(prim_poly(m));
		for (int i = MAX_M - 1; i >= 0; i--) begin
			if (i < m) begin
				p = p << 1;
				if (p[m])
					p = p ^ poly;
				if (b[i])
					p = p ^ {1'b0, a};
			end
		end
		return p[MAX_M-1:0];
	endfunction

	function automatic logic [MAX_M-1:0] gf_sq(input int m, input logic [MAX_M-1:0] a);
		return gf_mul(m, a, a);
	endfunction

	// alpha^e by square and multiply over the bits of e mod n.
	function automatic logic [MAX_M-1:0] alpha_pow(input int m, input int e);
		logic [MAX_M-1:0] r;
		int ee;
		ee = e % ((1 << m) - 1);
		r = 1;
		for (int i = 31; i >= 0; i--) begin
			r = gf_sq(m, r);
			if (ee[i])
				r = gf_mul(m, r, 2);	// times alpha.
		end
		return r;
	endfunction

endpackage

// File: src/lfsr_counter.sv
`timescale 1ns/100ps

module lfsr_counter #(
	parameter int M = 4
) (
	input  logic         clk,
	input  logic         rst_n,
	input  logic         restart,
	input  logic         advance,
	output logic [M-1:0] count
);
	import bch_pkg::*;

	localparam logic [M-1:0] SEED = M'(1);

	// restart with advance counts the restarting bit itself.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= SEED;
		end else if (restart) begin
			count <= advance ? M'(lfsr_next(M, SEED)) : SEED;
		end else if (advance) begin
			count <= M'(lfsr_next(M, count));
		end
	end

	// the all zero state would lock the counter up.
	assert property (@(posedge clk) disable iff (!rst_n) count != '0)
		else $error("bit counter reached the all zero state.");

endmodule

// File: test/tb_bch_ref.svh
function automatic logic [M-1:0] times_alpha(input logic [M-1:0] a);
	logic [M:0] p;
	p = {a, 1'b0};
	if (p[M])
		p = p ^ POLY;	// fold x^M back into the field.
	return p[M-1:0];
endfunction

function automatic logic [M-1:0] power_of_alpha(input int e);
	logic [M-1:0] r;
	r = 1;
	repeat (e % N)
		r = times_alpha(r);
	return r;
endfunction

// r(alpha^k) where word[i] is the coefficient of x^i.
function automatic logic [M-1:0] eval_received(input logic [N-1:0] word, input int k);
	logic [M-1:0] s;
	s = '0;
	for (int i = 0; i < N; i++)
		if (word[i])
			s = s ^ power_of_alpha(k * i);
	return s;
endfunction

// slot i holds S_k with k = ((2T+1-i) mod (2T-1)) + 1.
function automatic logic [W-1:0] window_of_word(input logic [N-1:0] word);
	logic [W-1:0] w;
	for (int i = 0; i < SLOTS; i++)
		w[i*M +: M] = eval_received(word, ((2 * T + 1 - i) % SLOTS) + 1);
	return w;
endfunction

// one solver step moves old slot (i+2T-3) mod (2T-1) into slot i.
function automatic logic [W-1:0] rotated_window(input logic [W-1:0] w);
	logic [W-1:0] r;
	for (int i = 0; i < SLOTS; i++)
		r[i*M +: M] = w[((i + 2 * T - 3) % SLOTS) * M +: M];
	return r;
endfunction

// File: test/tb_bch_syndrome.sv
`timescale 1ns/100ps

module tb_bch_syndrome;

	localparam int M = 4;
	localparam int T = 3;
	localparam int N = (1 << M) - 1;
	localparam int SLOTS = 2 * T - 1;
	localparam int W = SLOTS * M;
	localparam logic [M:0] POLY = 5'h13;	// x^4 + x + 1.
	localparam int MAX_CYCLES = 40 * 100;	// 40 words of under 100 cycles each with stalls.

	logic clk;
	logic rst_n;
	logic bit_valid;
	logic bit_ready;
	logic bit_data;
	logic bit_first;
	logic step;
	logic win_release;
	logic win_valid;
	logic [W-1:0] win_data;

	logic last_bit;	// bit n of the word is on the bus.
	logic [W-1:0] word_win;	// expected window of the word being sent.
	logic rst_q;
	logic m_syn_valid;
	logic m_syn_ready;
	logic [W-1:0] m_syn_win;
	logic m_win_valid;
	logic [W-1:0] m_win;
	logic exp_ready;
	logic last_accept;
	logic armed;
	int errors = 0;
	int cycles = 0;
	int seed;
	string test_name;

	`include "tb_bch_ref.svh"

	bch_syndrome_top u_dut (
		.clk(clk),
		.rst_n(rst_n),
		.bit_valid(bit_valid),
		.bit_ready(bit_ready),
		.bit_data(bit_data),
		.bit_first(bit_first),
		.step(step),
		.win_release(win_release),
		.win_valid(win_valid),
		.win_data(win_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	assign m_syn_ready = !m_win_valid || win_release;
	assign exp_ready = rst_q && !(m_syn_valid && !m_syn_ready);	// low while a block waits.
	assign last_accept = bit_valid && bit_ready && last_bit && !m_syn_valid && !m_win_valid;

	// expected handshake and window state.
	always @(posedge clk) begin
		rst_q <= rst_n;
		if (!rst_n) begin
			m_syn_valid <= 1'b0;
			m_win_valid <= 1'b0;
		end else begin
			if (bit_valid && bit_ready && last_bit) begin
				m_syn_valid <= 1'b1;
				m_syn_win <= word_win;
			end else if (m_syn_ready) begin
				m_syn_valid <= 1'b0;
			end
			if (m_syn_valid && m_syn_ready) begin
				m_win_valid <= 1'b1;
				m_win <= m_syn_win;
			end else begin
				if (win_release)
					m_win_valid <= 1'b0;
				if (step && m_win_valid)
					m_win <= rotated_window(m_win);
			end
		end
	end

	assert property (@(posedge clk) disable iff (!armed) bit_ready == exp_ready)
		else begin
			errors++;
			$display("CHECK FAILED %s: bit_ready expected %b, actual %b", test_name,
				$sampled(exp_ready), $sampled(bit_ready));
		end

	assert property (@(posedge clk) disable iff (!armed) win_valid == m_win_valid)
		else begin
			errors++;
			$display("CHECK FAILED %s: win_valid expected %b, actual %b", test_name,
				$sampled(m_win_valid), $sampled(win_valid));
		end

	assert property (@(posedge clk) disable iff (!armed) m_win_valid |-> win_data == m_win)
		else begin
			errors++;
			$display("CHECK FAILED %s: window expected %h, actual %h", test_name,
				$sampled(m_win), $sampled(win_data));
		end

	assert property (@(posedge clk) disable iff (!armed) last_accept |-> ##2 win_valid)
		else begin
			errors++;
			$display("%s: window did not appear two cycles after the last bit.", test_name);
		end

	// sends one codeword first bit first with optional idle cycles on bit_valid.
	task automatic send_word(input logic [N-1:0] word, input bit stall);
		int p;
		p = 0;
		word_win = window_of_word(word);
		while (p < N) begin
			@(negedge clk);
			bit_valid = !(stall && ($random(seed) & 3) == 0);
			bit_data = word[N-1-p];
			bit_first = (p == 0);
			last_bit = (p == N - 1);
			@(posedge clk);
			if (bit_valid && bit_ready)
				p++;
		end
		@(negedge clk);
		bit_valid = 1'b0;
		bit_first = 1'b0;
		last_bit = 1'b0;
	endtask

	// solver side waits for a window, steps it, then frees it.
	task automatic consume_window(input int steps, input int hold);
		@(negedge clk);
		while (!win_valid)
			@(negedge clk);
		for (int s = 0; s < steps; s++) begin
			step = 1'b1;
			@(negedge clk);
		end
		step = 1'b0;
		repeat (hold) @(negedge clk);
		win_release = 1'b1;
		@(negedge clk);
		win_release = 1'b0;
	endtask

	initial begin
		logic [N-1:0] word;
		int n_steps;
		int n_hold;
		seed = 91;
		rst_n = 1'b0;
		bit_valid = 1'b0;
		bit_data = 1'b0;
		bit_first = 1'b0;
		last_bit = 1'b0;
		step = 1'b0;
		win_release = 1'b0;
		word_win = '0;
		armed = 1'b0;
		test_name = "reset";
		@(posedge clk);
		@(negedge clk);
		armed = 1'b1;	// outputs are defined after the first reset edge.
		repeat (9) @(negedge clk);
		rst_n = 1'b1;
		repeat (3) @(negedge clk);

		test_name = "zero";
		send_word('0, 1'b0);
		consume_window(2, 0);

		test_name = "single";
		for (int p = 0; p < N; p++) begin
			word = '0;
			word[N-1-p] = 1'b1;	// stream position p.
			send_word(word, 1'b0);
			consume_window(1, 0);
		end

		test_name = "random";
		for (int w = 0; w < 20; w++) begin
			word = N'($random(seed));
			send_word(word, 1'b1);
			n_steps = $random(seed) & 7;
			n_hold = $random(seed) & 3;
			consume_window(n_steps, n_hold);
		end

		// the second block waits while the first window is held.
		test_name = "backpressure";
		send_word(N'($random(seed)), 1'b0);
		send_word(N'($random(seed)), 1'b1);
		fork
			send_word(N'($random(seed)), 1'b1);
			begin
				repeat (20) @(negedge clk);
				consume_window(2, 0);
				consume_window(3, 1);
			end
		join
		consume_window(4, 0);
		repeat (3) @(negedge clk);

		$display("run complete, %0d errors", errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout: the run did not end within %0d cycles, %0d errors",
				MAX_CYCLES, errors);
			$display("Finished with errors");
			$finish;
		end
	end

endmodule
